// ==== hw/nts_params.svh ====
//--------------------------------------------------
// Sizes shared by the RTL. A buffer holds at most
// 2**NTS_BUF_ADDR_BITS - 1 words of one packet.
//--------------------------------------------------
`ifndef NTS_PARAMS_SVH
`define NTS_PARAMS_SVH

// Data path width, a whole number of bytes
`define NTS_WORD_BITS 64

// Ring of 4 buffers with 256 words each
`define NTS_BUF_SEL_BITS 2
`define NTS_BUF_ADDR_BITS 8

`define NTS_CNT_BITS 32

`endif

// ==== hw/nts_buffer_pkg.sv ====
//--------------------------------------------------
// Types for the packet buffer ring
//--------------------------------------------------
`include "nts_params.svh"

package nts_buffer_pkg;

  localparam int NUM_BUFS = 1 << `NTS_BUF_SEL_BITS;
  localparam int RAM_WORDS = 1 << (`NTS_BUF_SEL_BITS + `NTS_BUF_ADDR_BITS);

  typedef enum logic [1:0] {UNUSED, WRITING, LOADED, READING} buf_state_t;

  typedef logic [`NTS_BUF_SEL_BITS-1:0] buf_sel_t;
  typedef logic [`NTS_BUF_ADDR_BITS-1:0] buf_addr_t;

  // Buffer index in the upper bits, word offset below
  typedef struct packed {
    buf_sel_t sel;
    buf_addr_t addr;
  } ram_addr_t;

  typedef logic [`NTS_WORD_BITS-1:0] word_t;
  typedef logic [3:0] lwb_t;

endpackage

// ==== hw/nts_tx_pkg.sv ====
//--------------------------------------------------
// Transmit side types and byte order helpers
//--------------------------------------------------
`include "nts_params.svh"

package nts_tx_pkg;

  localparam int WORD_BYTES = `NTS_WORD_BITS / 8;

  typedef enum logic [1:0] {IDLE, AWAIT_ACK, WRITE, WRITE_LAST} tx_state_t;

  typedef logic [WORD_BYTES-1:0] valid_mask_t;

  // Byte 0 of the MAC word takes the top byte of the buffer word
  function automatic nts_buffer_pkg::word_t byte_reverse(input nts_buffer_pkg::word_t data,
                                                         input valid_mask_t mask);
    nts_buffer_pkg::word_t result;
    result = '0;
    for (int i = 0; i < WORD_BYTES; i++) begin
      if (mask[i]) begin
        result[8*i +: 8] = data[8*(WORD_BYTES-1-i) +: 8];
      end
    end
    return result;
  endfunction

  // n valid bytes give n low ones
  function automatic valid_mask_t lwb_to_mask(input nts_buffer_pkg::lwb_t n);
    valid_mask_t mask;
    for (int i = 0; i < WORD_BYTES; i++) begin
      mask[i] = (i < n);
    end
    return mask;
  endfunction

endpackage

// ==== hw/buf_ctrl_if.sv ====
//--------------------------------------------------
// Buffer ring control. Strobes last one cycle,
// state and selected fields are levels
//--------------------------------------------------
`timescale 1ns/1ps

interface buf_ctrl_if;

  // Write side
  logic eng_claim;
  logic eng_advance;
  logic eng_done;
  nts_buffer_pkg::lwb_t eng_lwb;
  nts_buffer_pkg::buf_state_t eng_state;
  nts_buffer_pkg::buf_sel_t eng_sel;
  nts_buffer_pkg::buf_addr_t eng_fill_addr;

  // Read side
  logic tx_loaded;
  nts_buffer_pkg::buf_sel_t tx_sel;
  nts_buffer_pkg::buf_addr_t tx_end_addr;
  nts_buffer_pkg::lwb_t tx_lwb;
  logic tx_claim;
  logic tx_release;

  modport reader (output eng_claim, eng_advance, eng_done, eng_lwb,
                  input eng_state, eng_sel, eng_fill_addr);
  modport tx (output tx_claim, tx_release,
              input tx_loaded, tx_sel, tx_end_addr, tx_lwb);
  modport store (input eng_claim, eng_advance, eng_done, eng_lwb, tx_claim, tx_release,
                 output eng_state, eng_sel, eng_fill_addr,
                 tx_loaded, tx_sel, tx_end_addr, tx_lwb);

endinterface

// ==== hw/packet_buffer.sv ====
//--------------------------------------------------
// Ring of packet buffers in one dual-port RAM.
// Read data comes one cycle after the address
//--------------------------------------------------
`timescale 1ns/1ps

module packet_buffer (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_wr_en,
  input  nts_buffer_pkg::ram_addr_t i_wr_addr,
  input  nts_buffer_pkg::word_t     i_wr_data,
  input  nts_buffer_pkg::ram_addr_t i_rd_addr,
  output nts_buffer_pkg::word_t     o_rd_data,
  buf_ctrl_if.store                 ctrl
);

  nts_buffer_pkg::word_t mem [nts_buffer_pkg::RAM_WORDS];

  nts_buffer_pkg::buf_state_t state_q [nts_buffer_pkg::NUM_BUFS];
  nts_buffer_pkg::buf_addr_t fill_q [nts_buffer_pkg::NUM_BUFS];
  nts_buffer_pkg::lwb_t lwb_q [nts_buffer_pkg::NUM_BUFS];

  nts_buffer_pkg::buf_sel_t eng_sel_q;
  nts_buffer_pkg::buf_sel_t tx_sel_q;

  //--------------------------------------------------
  // RAM
  //--------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_rd_addr];
  end

  //--------------------------------------------------
  // Buffer table
  //--------------------------------------------------

  // The write side only touches UNUSED or WRITING buffers and the read
  // side only LOADED or READING ones, so both may update in one cycle
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < nts_buffer_pkg::NUM_BUFS; i++) begin
        state_q[i] <= nts_buffer_pkg::UNUSED;
        fill_q[i] <= '0;
        lwb_q[i] <= '0;
      end
      eng_sel_q <= '0;
      tx_sel_q <= '0;
    end else begin
      if (ctrl.eng_claim) begin
        state_q[eng_sel_q] <= nts_buffer_pkg::WRITING;
        fill_q[eng_sel_q] <= '0;
        lwb_q[eng_sel_q] <= ctrl.eng_lwb;
      end
      if (ctrl.eng_advance) begin
        fill_q[eng_sel_q] <= fill_q[eng_sel_q] + 1'b1;
      end
      if (ctrl.eng_done) begin
        state_q[eng_sel_q] <= nts_buffer_pkg::LOADED;
        eng_sel_q <= eng_sel_q + 1'b1;
      end

      if (ctrl.tx_claim) begin
        state_q[tx_sel_q] <= nts_buffer_pkg::READING;
      end
      if (ctrl.tx_release) begin
        state_q[tx_sel_q] <= nts_buffer_pkg::UNUSED;
        tx_sel_q <= tx_sel_q + 1'b1;
      end
    end
  end

  // Fields of the buffer each side is working on
  assign ctrl.eng_sel = eng_sel_q;
  assign ctrl.eng_state = state_q[eng_sel_q];
  assign ctrl.eng_fill_addr = fill_q[eng_sel_q];

  assign ctrl.tx_sel = tx_sel_q;
  assign ctrl.tx_loaded = (state_q[tx_sel_q] == nts_buffer_pkg::LOADED);
  assign ctrl.tx_end_addr = fill_q[tx_sel_q];
  assign ctrl.tx_lwb = lwb_q[tx_sel_q];

endmodule

// ==== hw/engine_reader.sv ====
//--------------------------------------------------
// Copies one engine packet per buffer. The FIFO
// returns a popped word on the following cycle
//--------------------------------------------------
`timescale 1ns/1ps

module engine_reader (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_engine_packet_available,
  input  logic                      i_engine_fifo_empty,
  input  nts_buffer_pkg::word_t     i_engine_fifo_rd_data,
  input  nts_buffer_pkg::lwb_t      i_engine_bytes_last_word,
  output logic                      o_engine_fifo_rd_en,
  output logic                      o_engine_packet_read,
  output logic                      o_wr_en,
  output nts_buffer_pkg::ram_addr_t o_wr_addr,
  output nts_buffer_pkg::word_t     o_wr_data,
  buf_ctrl_if.reader                ctrl
);

  logic word_valid_q;
  logic packet_read_q;
  logic writing;
  logic claim;

  assign writing = (ctrl.eng_state == nts_buffer_pkg::WRITING);

  // Hold off while packet_read is out so the engine can move to its next packet
  assign claim = (ctrl.eng_state == nts_buffer_pkg::UNUSED) && i_engine_packet_available &&
                 !i_engine_fifo_empty && !packet_read_q;

  assign o_engine_fifo_rd_en = !i_engine_fifo_empty && (writing || claim);

  assign ctrl.eng_claim = claim;
  assign ctrl.eng_lwb = i_engine_bytes_last_word;
  assign ctrl.eng_advance = word_valid_q;
  // Done once the FIFO is drained and no popped word is still in flight
  assign ctrl.eng_done = writing && i_engine_fifo_empty && !word_valid_q;

  assign o_engine_packet_read = packet_read_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      word_valid_q <= 1'b0;
      packet_read_q <= 1'b0;
      o_wr_en <= 1'b0;
      o_wr_addr <= '0;
      o_wr_data <= '0;
    end else begin
      word_valid_q <= o_engine_fifo_rd_en;
      packet_read_q <= ctrl.eng_done;
      // Staging register in front of the RAM write port
      o_wr_en <= word_valid_q;
      o_wr_addr <= '{sel: ctrl.eng_sel, addr: ctrl.eng_fill_addr};
      o_wr_data <= i_engine_fifo_rd_data;
    end
  end

endmodule

// ==== hw/mac_tx_fsm.sv ====
//--------------------------------------------------
// Sends loaded buffers to the MAC. Once acked the
// packet goes out at one word per cycle, no stall
//--------------------------------------------------
`timescale 1ns/1ps

module mac_tx_fsm (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic                      i_mac_tx_ack,
  output nts_buffer_pkg::ram_addr_t o_rd_addr,
  input  nts_buffer_pkg::word_t     i_rd_data,
  buf_ctrl_if.tx                    ctrl,
  output logic                      o_mac_tx_start,
  output nts_tx_pkg::valid_mask_t   o_mac_tx_data_valid,
  output nts_buffer_pkg::word_t     o_mac_tx_data
);

  nts_tx_pkg::tx_state_t state_q;
  nts_buffer_pkg::buf_addr_t rd_cnt_q;
  nts_buffer_pkg::buf_addr_t rd_next;
  logic last_next;
  nts_tx_pkg::valid_mask_t mask;

  assign rd_next = rd_cnt_q + 1'b1;
  // Next read would pass the fill address, so the word in flight is the last
  assign last_next = (rd_next >= ctrl.tx_end_addr);

  assign o_rd_addr = '{sel: ctrl.tx_sel, addr: rd_cnt_q};

  assign ctrl.tx_claim = (state_q == nts_tx_pkg::IDLE) && ctrl.tx_loaded;
  assign ctrl.tx_release = (state_q == nts_tx_pkg::WRITE_LAST);

  always_comb begin
    case (state_q)
      nts_tx_pkg::WRITE:      mask = '1;
      nts_tx_pkg::WRITE_LAST: mask = nts_tx_pkg::lwb_to_mask(ctrl.tx_lwb);
      default:                mask = '0;
    endcase
  end

  //--------------------------------------------------
  // State and read address
  //--------------------------------------------------

  // Word 0 is read while waiting for ack, so each WRITE cycle emits the
  // word one behind the current read address
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= nts_tx_pkg::IDLE;
      rd_cnt_q <= '0;
      o_mac_tx_start <= 1'b0;
      o_mac_tx_data_valid <= '0;
    end else begin
      o_mac_tx_start <= ctrl.tx_claim;
      o_mac_tx_data_valid <= mask;
      case (state_q)
        nts_tx_pkg::IDLE: begin
          if (ctrl.tx_loaded) begin
            rd_cnt_q <= '0;
            state_q <= nts_tx_pkg::AWAIT_ACK;
          end
        end
        nts_tx_pkg::AWAIT_ACK: begin
          if (i_mac_tx_ack) begin
            rd_cnt_q <= rd_next;
            state_q <= last_next ? nts_tx_pkg::WRITE_LAST : nts_tx_pkg::WRITE;
          end
        end
        nts_tx_pkg::WRITE: begin
          rd_cnt_q <= rd_next;
          if (last_next) begin
            state_q <= nts_tx_pkg::WRITE_LAST;
          end
        end
        default: state_q <= nts_tx_pkg::IDLE;
      endcase
    end
  end

  // Masked bytes come out as zero, so idle cycles carry zero data
  always_ff @(posedge i_clk) begin
    o_mac_tx_data <= nts_tx_pkg::byte_reverse(i_rd_data, mask);
  end

endmodule

// ==== hw/tx_stat_counters.sv ====
//--------------------------------------------------
// Byte and packet totals, wrapping at full width
//--------------------------------------------------
`timescale 1ns/1ps
`include "nts_params.svh"

module tx_stat_counters (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  logic                     i_mac_tx_start,
  input  nts_tx_pkg::valid_mask_t  i_mac_tx_data_valid,
  output logic [`NTS_CNT_BITS-1:0] o_bytes_sent,
  output logic [`NTS_CNT_BITS-1:0] o_packets_sent
);

  localparam int CW = `NTS_CNT_BITS;

  logic [CW-1:0] word_bytes;

  // Every valid bit is one byte on the wire
  assign word_bytes = CW'($countones(i_mac_tx_data_valid));

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_bytes_sent <= '0;
      o_packets_sent <= '0;
    end else begin
      o_bytes_sent <= o_bytes_sent + word_bytes;
      if (i_mac_tx_start) begin
        o_packets_sent <= o_packets_sent + 1'b1;
      end
    end
  end

endmodule

// ==== hw/nts_extractor.sv ====
//--------------------------------------------------
// Engine FIFO to MAC packet extractor. Packets must
// fit one buffer and the MAC may not stall after ack
//--------------------------------------------------
`timescale 1ns/1ps
`include "nts_params.svh"

module nts_extractor (
  input  logic                         i_areset,
  input  logic                         i_clk,

  input  logic                         i_engine_packet_available,
  output logic                         o_engine_packet_read,
  input  logic                         i_engine_fifo_empty,
  output logic                         o_engine_fifo_rd_en,
  input  logic [`NTS_WORD_BITS-1:0]    i_engine_fifo_rd_data,
  input  logic [3:0]                   i_engine_bytes_last_word,

  output logic                         o_mac_tx_start,
  input  logic                         i_mac_tx_ack,
  output logic [`NTS_WORD_BITS/8-1:0]  o_mac_tx_data_valid,
  output logic [`NTS_WORD_BITS-1:0]    o_mac_tx_data,

  output logic [`NTS_CNT_BITS-1:0]     o_bytes_sent,
  output logic [`NTS_CNT_BITS-1:0]     o_packets_sent
);

  buf_ctrl_if ctrl ();

  logic wr_en;
  nts_buffer_pkg::ram_addr_t wr_addr;
  nts_buffer_pkg::word_t wr_data;
  nts_buffer_pkg::ram_addr_t rd_addr;
  nts_buffer_pkg::word_t rd_data;

  packet_buffer u_buffer (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data),
    .ctrl      (ctrl.store)
  );

  engine_reader u_reader (
    .i_clk                     (i_clk),
    .i_areset                  (i_areset),
    .i_engine_packet_available (i_engine_packet_available),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_engine_packet_read      (o_engine_packet_read),
    .o_wr_en                   (wr_en),
    .o_wr_addr                 (wr_addr),
    .o_wr_data                 (wr_data),
    .ctrl                      (ctrl.reader)
  );

  mac_tx_fsm u_tx (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_rd_addr           (rd_addr),
    .i_rd_data           (rd_data),
    .ctrl                (ctrl.tx),
    .o_mac_tx_start      (o_mac_tx_start),
    .o_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_mac_tx_data       (o_mac_tx_data)
  );

  // Totals are taken from the MAC side outputs
  tx_stat_counters u_stats (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_mac_tx_start      (o_mac_tx_start),
    .i_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_bytes_sent        (o_bytes_sent),
    .o_packets_sent      (o_packets_sent)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
//--------------------------------------------------
// 4 ns clock, reset held high for the first 4 edges
//--------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_areset
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  initial begin
    o_areset = 1'b1;
    repeat (4) @(posedge o_clk);
    o_areset <= 1'b0;
  end

endmodule

// ==== testbench/nts_extractor_asserts.sv ====
//--------------------------------------------------
// Protocol checks on the extractor top level ports
//--------------------------------------------------
`timescale 1ns/1ps
`include "nts_params.svh"

module nts_extractor_asserts (
  input logic                          i_clk,
  input logic                          i_areset,
  input logic                          i_engine_packet_read,
  input logic                          i_engine_fifo_rd_en,
  input logic                          i_mac_tx_start,
  input logic                          i_mac_tx_ack,
  input logic [`NTS_WORD_BITS/8-1:0]   i_mac_tx_data_valid,
  input logic [`NTS_CNT_BITS-1:0]      i_bytes_sent,
  input logic [`NTS_CNT_BITS-1:0]      i_packets_sent
);

  int fail_count;
  logic quiet;
  logic awaiting_ack_q;

  initial fail_count = 0;

  assign quiet = !i_mac_tx_start && (i_mac_tx_data_valid == '0) && !i_engine_fifo_rd_en &&
                 !i_engine_packet_read && (i_bytes_sent == '0) && (i_packets_sent == '0);

  // High from the start pulse up to and including the ack cycle
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      awaiting_ack_q <= 1'b0;
    end else if (i_mac_tx_start) begin
      awaiting_ack_q <= 1'b1;
    end else if (i_mac_tx_ack) begin
      awaiting_ack_q <= 1'b0;
    end
  end

  reset_quiet: assert property (@(posedge i_clk) (i_areset || $fell(i_areset)) |-> quiet)
    else begin
      fail_count++;
      $error("strobe or total not zero around reset");
    end

  no_data_before_ack: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_mac_tx_start || awaiting_ack_q) |-> (i_mac_tx_data_valid == '0))
    else begin
      fail_count++;
      $error("MAC data valid before ack");
    end

  mask_low_ones: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_mac_tx_data_valid != '0) |->
      ((i_mac_tx_data_valid & (i_mac_tx_data_valid + 8'd1)) == 8'd0))
    else begin
      fail_count++;
      $error("valid mask is not a run of low ones");
    end

  // A partial mask closes the packet
  partial_mask_last: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_mac_tx_data_valid != '0 && i_mac_tx_data_valid != 8'hff) |=>
      (i_mac_tx_data_valid == '0))
    else begin
      fail_count++;
      $error("partial mask not on the last word");
    end

  packets_on_start: assert property (@(posedge i_clk) disable iff (i_areset)
    1'b1 |=> (i_packets_sent == $past(i_packets_sent) + 32'($past(i_mac_tx_start))))
    else begin
      fail_count++;
      $error("packet total does not follow start pulses");
    end

  bytes_on_valid: assert property (@(posedge i_clk) disable iff (i_areset)
    1'b1 |=> (i_bytes_sent == $past(i_bytes_sent) + 32'($countones($past(i_mac_tx_data_valid)))))
    else begin
      fail_count++;
      $error("byte total does not follow valid masks");
    end

endmodule

bind nts_extractor nts_extractor_asserts u_asserts (
  .i_clk                (i_clk),
  .i_areset             (i_areset),
  .i_engine_packet_read (o_engine_packet_read),
  .i_engine_fifo_rd_en  (o_engine_fifo_rd_en),
  .i_mac_tx_start       (o_mac_tx_start),
  .i_mac_tx_ack         (i_mac_tx_ack),
  .i_mac_tx_data_valid  (o_mac_tx_data_valid),
  .i_bytes_sent         (o_bytes_sent),
  .i_packets_sent       (o_packets_sent)
);

// ==== testbench/nts_extractor_tb.sv ====
//--------------------------------------------------
// Engine FIFO and MAC models around the extractor.
// Packets of 1 to 20 words, ack delay 0 to 7 cycles
//--------------------------------------------------
`timescale 1ns/1ps
`include "nts_params.svh"

module nts_extractor_tb;

  localparam int NUM_PKTS = 48;

  logic clk;
  logic areset;
  logic engine_available;
  logic packet_read;
  logic fifo_empty;
  logic fifo_rd_en;
  logic [`NTS_WORD_BITS-1:0] fifo_data;
  logic [3:0] fifo_lwb;
  logic mac_start;
  logic mac_ack;
  logic [`NTS_WORD_BITS/8-1:0] mac_valid;
  logic [`NTS_WORD_BITS-1:0] mac_data;
  logic [`NTS_CNT_BITS-1:0] bytes_sent;
  logic [`NTS_CNT_BITS-1:0] packets_sent;

  logic [31:0] lfsr_q = 32'h8988;
  int pkt_len [NUM_PKTS];
  logic [3:0] pkt_lwb [NUM_PKTS];
  logic [63:0] pkt_words [$];
  logic [63:0] fifo_q [$];
  logic [63:0] exp_data [$];
  logic [7:0] exp_mask [$];
  bit exp_last [$];
  int total_bytes = 0;
  int next_pkt = 0;
  int word_pos = 0;
  bit need_packet = 1'b1;
  int ack_wait = -1;
  int packets_seen = 0;
  int words_seen = 0;
  int full_cycles = 0;
  int data_errors = 0;
  int other_errors = 0;
  int assert_errors = 0;

  tb_clock_gen u_clock (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_extractor uut (
    .i_areset                  (areset),
    .i_clk                     (clk),
    .i_engine_packet_available (engine_available),
    .o_engine_packet_read      (packet_read),
    .i_engine_fifo_empty       (fifo_empty),
    .o_engine_fifo_rd_en       (fifo_rd_en),
    .i_engine_fifo_rd_data     (fifo_data),
    .i_engine_bytes_last_word  (fifo_lwb),
    .o_mac_tx_start            (mac_start),
    .i_mac_tx_ack              (mac_ack),
    .o_mac_tx_data_valid       (mac_valid),
    .o_mac_tx_data             (mac_data),
    .o_bytes_sent              (bytes_sent),
    .o_packets_sent            (packets_sent)
  );

  //--------------------------------------------------
  // Random source and expected values
  //--------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [63:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value = {value[62:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [7:0] last_word_mask(input logic [3:0] n);
    return 8'((9'd1 << n) - 9'd1);
  endfunction

  // MAC byte 0 is the top engine byte, bytes outside the mask read as zero
  function automatic logic [63:0] mac_word(input logic [63:0] word, input logic [7:0] mask);
    logic [63:0] swapped;
    logic [63:0] keep;
    swapped = {<<8{word}};
    for (int b = 0; b < 8; b++) begin
      keep[8*b +: 8] = {8{mask[b]}};
    end
    return swapped & keep;
  endfunction

  task automatic make_packets();
    logic [63:0] bits;
    logic [7:0] mask;
    int len;
    for (int p = 0; p < NUM_PKTS; p++) begin
      draw_bits(5, bits);
      len = int'(bits[4:0]) % 20 + 1;
      draw_bits(3, bits);
      pkt_len[p] = len;
      pkt_lwb[p] = 4'(bits[2:0]) + 4'd1;
      total_bytes += (len - 1) * 8 + int'(pkt_lwb[p]);
      for (int i = 0; i < len; i++) begin
        draw_bits(64, bits);
        mask = (i == len - 1) ? last_word_mask(pkt_lwb[p]) : 8'hff;
        pkt_words.push_back(bits);
        exp_data.push_back(mac_word(bits, mask));
        exp_mask.push_back(mask);
        exp_last.push_back(i == len - 1);
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      data_errors++;
    end
  endtask

  //--------------------------------------------------
  // Engine FIFO model
  //--------------------------------------------------

  // A popped word shows up one cycle later; the next packet is offered
  // right after packet_read so the ring fills when the MAC is slow
  always @(posedge clk) begin
    logic [63:0] word;
    if (!areset) begin
      if (fifo_rd_en) begin
        if (fifo_q.size() == 0) begin
          $display("Error: the DUT read from an empty engine FIFO");
          other_errors++;
        end else begin
          word = fifo_q.pop_front();
          fifo_data <= word;
          fifo_empty <= (fifo_q.size() == 0);
        end
      end
      // Words waiting and no pop means the next buffer is still in use
      if (engine_available && !fifo_empty && !fifo_rd_en && !packet_read) begin
        full_cycles++;
      end
      if (packet_read) begin
        need_packet = 1'b1;
      end
      if (need_packet) begin
        need_packet = 1'b0;
        if (next_pkt < NUM_PKTS) begin
          for (int i = 0; i < pkt_len[next_pkt]; i++) begin
            fifo_q.push_back(pkt_words[word_pos]);
            word_pos++;
          end
          engine_available <= 1'b1;
          fifo_empty <= 1'b0;
          fifo_lwb <= pkt_lwb[next_pkt];
          next_pkt++;
        end else begin
          engine_available <= 1'b0;
        end
      end
    end
  end

  //--------------------------------------------------
  // MAC model and data check
  //--------------------------------------------------

  always @(posedge clk) begin
    logic [63:0] bits;
    if (areset) begin
      mac_ack <= 1'b0;
      ack_wait = -1;
    end else begin
      mac_ack <= 1'b0;
      if (mac_start) begin
        draw_bits(3, bits);
        ack_wait = int'(bits[2:0]);
      end
      if (ack_wait == 0) begin
        mac_ack <= 1'b1;
        ack_wait = -1;
      end else if (ack_wait > 0) begin
        ack_wait--;
      end
    end
  end

  always @(posedge clk) begin
    bit last;
    if (!areset && mac_valid != '0) begin
      if (exp_data.size() == 0) begin
        $display("Error: MAC word with valid %h arrived after the last packet", mac_valid);
        other_errors++;
      end else begin
        last = exp_last.pop_front();
        compare_value($sformatf("packet %0d word %0d valid", packets_seen, words_seen),
                      64'(exp_mask.pop_front()), 64'(mac_valid));
        compare_value($sformatf("packet %0d word %0d data", packets_seen, words_seen),
                      exp_data.pop_front(), mac_data);
        words_seen = last ? 0 : words_seen + 1;
        if (last) begin
          packets_seen++;
        end
      end
    end
  end

  //--------------------------------------------------
  // Run control
  //--------------------------------------------------

  initial begin
    engine_available <= 1'b0;
    fifo_empty <= 1'b1;
    fifo_data <= '0;
    fifo_lwb <= '0;
    mac_ack <= 1'b0;
    make_packets();
    while (packets_seen < NUM_PKTS) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    compare_value("packets_sent total", 64'(NUM_PKTS), 64'(packets_sent));
    compare_value("bytes_sent total", 64'(total_bytes), 64'(bytes_sent));
    if (full_cycles == 0) begin
      $display("Error: the buffer ring never filled, back-pressure was not reached");
      other_errors++;
    end
    assert_errors = uut.u_asserts.fail_count;
    $display("Errors: %0d data, %0d other, %0d assertion", data_errors, other_errors,
             assert_errors);
    if (data_errors + other_errors + assert_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Worst packet needs well under 40 cycles on the MAC side
  initial begin
    repeat (NUM_PKTS * 40 + 1000) @(posedge clk);
    $display("Timeout: only %0d of %0d packets reached the MAC", packets_seen, NUM_PKTS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/nts_buffer_pkg.sv
hw/nts_tx_pkg.sv
hw/buf_ctrl_if.sv
hw/packet_buffer.sv
hw/engine_reader.sv
hw/mac_tx_fsm.sv
hw/tx_stat_counters.sv
hw/nts_extractor.sv
testbench/tb_clock_gen.sv
testbench/nts_extractor_asserts.sv
testbench/nts_extractor_tb.sv

// ==== Makefile ====
TOP := nts_extractor_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f hw/*.sv hw/*.svh testbench/*.sv
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@! grep -q "Result: FAILED" sim.log
	@grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module nts_extractor -f vlog.f

clean:
	rm -rf obj_dir sim.log
